//--- filelist.f
source/tlb_cfg_pkg.sv
source/tlb_types_pkg.sv
source/tlb_ifs.sv
source/tlb_req_decode.sv
source/tlb_lookup_exec.sv
source/tlb_entry_array.sv
source/tlb_result.sv
source/tlb_top.sv
tests/tlb_properties.sv
tests/tlb_tb.sv

//--- tests/tlb_tb.sv
// testbench for the data TLB with 4 ways, 4 request slots and 2 result credits
// each lookup is predicted when sent, fills wait until no lookup is in flight

module tlb_tb;
  localparam int WAYS = 4;
  localparam int SETS = tlb_cfg_pkg::SET_COUNT;
  localparam int IW = tlb_cfg_pkg::INDEX_WIDTH;
  localparam int TW = tlb_cfg_pkg::TAG_WIDTH;
  localparam int VW = tlb_cfg_pkg::VPN_WIDTH;
  localparam int AW = tlb_cfg_pkg::ASID_WIDTH;
  localparam int PW = tlb_cfg_pkg::PPN_WIDTH;
  localparam int OP_COUNT = 4 + 5 + 12 + 6 + 8 + 300;

  logic clk, rst, lookup_valid, lookup_credit, fill_valid, fill_invalidate, resp_credit;
  logic fill_writable, fill_user, fill_global, ready;
  logic result_valid, result_hit, result_writable, result_user;
  logic [VW-1:0] lookup_vpn, fill_vpn, rnd_vpn;
  logic [AW-1:0] lookup_asid, fill_asid;
  logic [PW-1:0] fill_ppn, result_ppn;
  logic [31:0] rnd;
  integer seed;
  int errors, checks, req_credits, owed, results_seen, credit_pulses, test_num;
  int base_results, base_pulses;
  bit hold_credits, random_credits, give_credit;
  tlb_types_pkg::tlb_entry_t model_entry [SETS][WAYS];
  int model_age [SETS][WAYS];
  tlb_types_pkg::lookup_result_t exp_q [$];
  tlb_types_pkg::lookup_result_t got_result;

  tlb_top #(.WAY_COUNT(WAYS), .REQ_DEPTH(4), .RESP_CREDITS(2)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (OP_COUNT * 20 + 1000) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", OP_COUNT * 20 + 1000);
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic check_result(input string name, input tlb_types_pkg::lookup_result_t got,
                              input tlb_types_pkg::lookup_result_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // the touched way becomes the youngest
  function automatic void refresh_age(input int set, input int way);
    int old;
    old = model_age[set][way];
    for (int w = 0; w < WAYS; w++) begin
      if (model_age[set][w] < old) model_age[set][w]++;
    end
    model_age[set][way] = 0;
  endfunction

  function automatic int find_way(input logic [VW-1:0] vpn, input logic [AW-1:0] asid);
    tlb_types_pkg::tlb_entry_t e;
    for (int w = 0; w < WAYS; w++) begin
      e = model_entry[vpn[IW-1:0]][w];
      if (e.valid && e.tag == vpn[VW-1:IW] && (e.asid == asid || e.attr.global_page)) return w;
    end
    return -1;
  endfunction

  function automatic tlb_types_pkg::lookup_result_t predict_lookup(input logic [VW-1:0] vpn,
                                                                  input logic [AW-1:0] asid);
    tlb_types_pkg::lookup_result_t r;
    int way;
    r = '0;
    way = find_way(vpn, asid);
    if (way >= 0) begin
      r.hit = 1'b1;
      r.ppn = model_entry[vpn[IW-1:0]][way].ppn;
      r.attr.writable = model_entry[vpn[IW-1:0]][way].attr.writable;
      r.attr.user = model_entry[vpn[IW-1:0]][way].attr.user;
      refresh_age(vpn[IW-1:0], way);
    end
    return r;
  endfunction

  // matching way first, else the oldest
  function automatic void model_fill(input logic [VW-1:0] vpn, input logic [AW-1:0] asid,
                                     input logic [PW-1:0] ppn,
                                     input tlb_types_pkg::page_attr_t attr, input logic inval);
    int set;
    int way;
    set = vpn[IW-1:0];
    way = find_way(vpn, asid);
    if (inval) begin
      if (way >= 0) model_entry[set][way].valid = 1'b0;
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (way < 0 && model_age[set][w] == WAYS - 1) way = w;
      end
      model_entry[set][way] = '{1'b1, vpn[VW-1:IW], asid, ppn, attr};
      refresh_age(set, way);
    end
  endfunction

  task automatic drain();
    while (exp_q.size() != 0 || owed != 0) @(posedge clk);
  endtask

  task automatic send_lookup(input logic [VW-1:0] vpn, input logic [AW-1:0] asid);
    @(posedge clk);
    #1;
    while (req_credits == 0) begin
      @(posedge clk);
      #1;
    end
    exp_q.push_back(predict_lookup(vpn, asid));
    req_credits--;
    lookup_valid = 1'b1;
    lookup_vpn = vpn;
    lookup_asid = asid;
    @(posedge clk);
    #1;
    lookup_valid = 1'b0;
  endtask

  task automatic send_fill(input logic [VW-1:0] vpn, input logic [AW-1:0] asid,
                           input logic [PW-1:0] ppn, input tlb_types_pkg::page_attr_t attr,
                           input logic inval);
    drain();
    @(posedge clk);
    #1;
    model_fill(vpn, asid, ppn, attr, inval);
    fill_valid = 1'b1;
    fill_vpn = vpn;
    fill_asid = asid;
    fill_ppn = ppn;
    {fill_writable, fill_user, fill_global} = attr;
    fill_invalidate = inval;
    @(posedge clk);
    #1;
    fill_valid = 1'b0;
    fill_invalidate = 1'b0;
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("test %0d %s finished, %0d errors so far", test_num, name, errors);
  endtask

  // compares results, counts credits and decides the next resp_credit
  always @(negedge clk) begin
    if (!rst) begin
      if (lookup_credit) begin
        req_credits++;
        credit_pulses++;
      end
      if (result_valid) begin
        results_seen++;
        owed++;
        check_count("ready", ready, 1);
        got_result = {result_hit, result_ppn, result_writable, result_user, 1'b0};
        if (exp_q.size() == 0) begin
          errors++;
          $display("a result arrived at %0t while no lookup was outstanding", $time);
        end else begin
          check_result("result", got_result, exp_q.pop_front());
        end
      end
      give_credit = owed > 0 && !hold_credits && (!random_credits || $random(seed) % 2 == 0);
    end
  end

  always @(posedge clk) begin
    #1;
    resp_credit = give_credit;
    if (give_credit) owed--;
  end

  initial begin
    seed = 32'hbec6;
    {lookup_valid, fill_valid, fill_invalidate, resp_credit, give_credit} = '0;
    {fill_writable, fill_user, fill_global} = '0;
    {lookup_vpn, fill_vpn, lookup_asid, fill_asid, fill_ppn} = '0;
    req_credits = 4;
    rst = 1'b1;
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        model_entry[s][w] = '0;
        model_age[s][w] = w;
      end
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // lookups queued during the sweep
    check_count("ready", ready, 0);
    for (int i = 0; i < 4; i++) send_lookup(VW'(i * 37), 8'd1);
    check_count("ready", ready, 0);
    drain();
    report_test("sweep");

    send_fill(20'h12345, 8'd5, 18'h2abcd, 3'b100, 1'b0);
    send_lookup(20'h12345, 8'd5);
    send_lookup(20'h12345, 8'd6);
    // any asid hits a global page
    send_fill(20'h54321, 8'd5, 18'h01234, 3'b011, 1'b0);
    send_lookup(20'h54321, 8'd9);
    drain();
    report_test("fill and asid");

    for (int t = 0; t < 4; t++) send_fill({TW'(256 + t), 4'h3}, 8'd2, PW'(100 + t), 3'b110, 1'b0);
    send_lookup({TW'(256), 4'h3}, 8'd2);
    send_lookup({TW'(258), 4'h3}, 8'd2);
    send_fill({TW'(260), 4'h3}, 8'd2, PW'(104), 3'b110, 1'b0);
    for (int t = 0; t < 5; t++) send_lookup({TW'(256 + t), 4'h3}, 8'd2);
    drain();
    report_test("replacement");

    send_fill({TW'(258), 4'h3}, 8'd2, '0, 3'b000, 1'b1);
    for (int t = 0; t < 5; t++) send_lookup({TW'(256 + t), 4'h3}, 8'd2);
    drain();
    report_test("invalidate");

    base_results = results_seen;
    base_pulses = credit_pulses;
    hold_credits = 1'b1;
    fork
      for (int i = 0; i < 8; i++) send_lookup({TW'(256 + i % 5), 4'h3}, 8'd2);
      begin
        // observation window with no credits returned
        repeat (40) @(posedge clk);
        check_count("results while held", results_seen - base_results, 2);
        check_count("lookup_credit while held", credit_pulses - base_pulses, 2);
        hold_credits = 1'b0;
      end
    join
    drain();
    check_count("lookup_credit total", credit_pulses - base_pulses, 8);
    report_test("back-pressure");

    random_credits = 1'b1;
    for (int n = 0; n < 300; n++) begin
      rnd = $random(seed);
      rnd_vpn = {TW'(8 + rnd[3:2] % 3), IW'(rnd[0])};
      if (rnd[7:4] < 4) begin
        // only tag 10 is global, so no two entries ever match one lookup
        send_fill(rnd_vpn, AW'(1 + rnd[1]), rnd[25:8],
                  {rnd[26], rnd[27], rnd[3:2] % 3 == 2}, 1'b0);
      end else if (rnd[7:4] == 4) begin
        send_fill(rnd_vpn, AW'(1 + rnd[1]), '0, 3'b000, 1'b1);
      end else begin
        send_lookup(rnd_vpn, AW'(1 + rnd[1]));
      end
    end
    drain();
    report_test("random");

    $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tests/tlb_properties.sv
// result credit checks, bound into every tlb_result instance
// assumes the consumer returns exactly one resp_credit per result it takes

module tlb_properties #(
  parameter int RESP_CREDITS = 2
) (
  input logic                                  clk,
  input logic                                  rst,
  input logic [$clog2(RESP_CREDITS + 1)-1:0]   credit_cnt,
  input logic                                  issue_grant,
  input logic                                  grant_d2,
  input logic                                  result_valid
);

  // counter starts full, only returned or refunded credits raise it
  credit_limit: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= RESP_CREDITS)
    else $error("result credit count above RESP_CREDITS");

  reset_quiet: assert property (@(posedge clk) rst |=> !result_valid && !issue_grant)
    else $error("result_valid or issue_grant active after a reset cycle");

  // a result leaves three cycles after the grant that reserved its credit
  result_reserved: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> $past(grant_d2))
    else $error("result_valid without a reserved result credit");

endmodule

bind tlb_result tlb_properties #(.RESP_CREDITS(RESP_CREDITS)) properties_i (
  .clk, .rst, .credit_cnt, .issue_grant, .grant_d2, .result_valid
);

//--- source/tlb_top.sv
// data TLB top level with credit channels for lookups and results
// the requester starts with REQ_DEPTH lookup credits, the consumer must return
// one resp_credit per result taken

module tlb_top #(
  parameter int WAY_COUNT = tlb_cfg_pkg::DEFAULT_WAYS,
  parameter int REQ_DEPTH = 4,
  parameter int RESP_CREDITS = 2
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               lookup_valid,
  input  logic [tlb_cfg_pkg::VPN_WIDTH-1:0]  lookup_vpn,
  input  logic [tlb_cfg_pkg::ASID_WIDTH-1:0] lookup_asid,
  output logic                               lookup_credit,
  input  logic                               fill_valid,
  input  logic [tlb_cfg_pkg::VPN_WIDTH-1:0]  fill_vpn,
  input  logic [tlb_cfg_pkg::ASID_WIDTH-1:0] fill_asid,
  input  logic [tlb_cfg_pkg::PPN_WIDTH-1:0]  fill_ppn,
  input  logic                               fill_writable,
  input  logic                               fill_user,
  input  logic                               fill_global,
  input  logic                               fill_invalidate,
  output logic                               result_valid,
  output logic                               result_hit,
  output logic [tlb_cfg_pkg::PPN_WIDTH-1:0]  result_ppn,
  output logic                               result_writable,
  output logic                               result_user,
  input  logic                               resp_credit,
  output logic                               ready
);

  tlb_types_pkg::page_attr_t fill_attr;
  logic                      issue_grant;

  tlb_issue_if issue_if ();
  tlb_result_if result_if ();
  tlb_array_if #(.WAY_COUNT(WAY_COUNT)) array_if ();

  assign fill_attr = '{writable: fill_writable, user: fill_user, global_page: fill_global};

  // low through reset and the sweep
  assign ready = !array_if.init_busy;

  tlb_req_decode #(.REQ_DEPTH(REQ_DEPTH)) decode_i (
    .clk, .rst, .lookup_valid, .lookup_vpn, .lookup_asid, .issue_grant,
    .init_busy(array_if.init_busy), .lookup_credit, .issue(issue_if.source)
  );

  tlb_lookup_exec #(.WAY_COUNT(WAY_COUNT)) exec_i (
    .clk, .rst, .fill_valid, .fill_vpn, .fill_asid, .fill_ppn, .fill_attr, .fill_invalidate,
    .issue(issue_if.sink), .array(array_if.master), .res(result_if.source)
  );

  tlb_entry_array #(.WAY_COUNT(WAY_COUNT)) array_i (
    .clk, .rst, .array(array_if.slave)
  );

  tlb_result #(.RESP_CREDITS(RESP_CREDITS)) result_i (
    .clk, .rst, .resp_credit, .issue_grant, .result_valid, .result_hit, .result_ppn,
    .result_writable, .result_user, .res(result_if.sink)
  );

endmodule

//--- source/tlb_result.sv
// result register and result-credit counter
// each grant reserves one credit, a grant that decode leaves unused is
// refunded two cycles later when no execute result shows up

module tlb_result #(
  parameter int RESP_CREDITS = 2
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              resp_credit,
  output logic                              issue_grant,
  output logic                              result_valid,
  output logic                              result_hit,
  output logic [tlb_cfg_pkg::PPN_WIDTH-1:0] result_ppn,
  output logic                              result_writable,
  output logic                              result_user,
  tlb_result_if.sink                        res
);

  localparam int CNT_W = $clog2(RESP_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;
  logic [CNT_W-1:0] credit_next;
  logic             grant_d1;
  logic             grant_d2;
  logic             refund;

  // execute answers a used grant exactly two cycles after it
  assign refund = grant_d2 && !res.valid;

  always_comb begin
    credit_next = credit_cnt;
    if (issue_grant) credit_next = credit_next - 1'b1;
    if (refund) credit_next = credit_next + 1'b1;
    if (resp_credit) credit_next = credit_next + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt   <= CNT_W'(RESP_CREDITS);
      issue_grant  <= 1'b0;
      grant_d1     <= 1'b0;
      grant_d2     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      credit_cnt   <= credit_next;
      issue_grant  <= (credit_next != '0);
      grant_d1     <= issue_grant;
      grant_d2     <= grant_d1;
      result_valid <= res.valid;
    end
  end

  always_ff @(posedge clk) begin
    result_hit      <= res.result.hit;
    result_ppn      <= res.result.ppn;
    result_writable <= res.result.attr.writable;
    result_user     <= res.result.attr.user;
  end

endmodule

//--- source/tlb_entry_array.sv
// entry and age storage, SET_COUNT sets of WAY_COUNT ways
// reads are combinational on two ports, writes land at the clock edge
// after reset a sweep of SET_COUNT cycles clears the sets and holds off all writes

module tlb_entry_array #(
  parameter int WAY_COUNT = tlb_cfg_pkg::DEFAULT_WAYS
) (
  input  logic       clk,
  input  logic       rst,
  tlb_array_if.slave array
);

  localparam int AGE_W = $clog2(WAY_COUNT);

  tlb_types_pkg::tlb_entry_t           entry_mem [tlb_cfg_pkg::SET_COUNT][WAY_COUNT];
  logic [WAY_COUNT-1:0][AGE_W-1:0]     age_mem [tlb_cfg_pkg::SET_COUNT];
  logic [tlb_cfg_pkg::INDEX_WIDTH-1:0] sweep_set;
  logic                                init_busy;

  assign array.init_busy = init_busy;

  // read ports
  for (genvar p = 0; p < 2; p++) begin : g_port
    for (genvar w = 0; w < WAY_COUNT; w++) begin : g_way
      assign array.rd_entries[p][w] = entry_mem[array.rd_index[p]][w];
    end
    assign array.rd_ages[p] = age_mem[array.rd_index[p]];
  end

  // sweep counter steps one set per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      sweep_set <= '0;
    end else if (init_busy) begin
      sweep_set <= sweep_set + 1'b1;
      if (sweep_set == tlb_cfg_pkg::INDEX_WIDTH'(tlb_cfg_pkg::SET_COUNT - 1)) begin
        init_busy <= 1'b0;
      end
    end
  end

  // the sweep leaves way i with age i, so way WAY_COUNT-1 is the first victim
  always_ff @(posedge clk) begin
    if (init_busy) begin
      for (int w = 0; w < WAY_COUNT; w++) begin
        entry_mem[sweep_set][w].valid <= 1'b0;
        age_mem[sweep_set][w] <= AGE_W'(w);
      end
    end else begin
      if (array.wr_en) begin
        entry_mem[array.wr_index][array.wr_way] <= array.wr_entry;
      end
      if (array.age_wr_en) begin
        age_mem[array.age_index] <= array.new_ages;
      end
    end
  end

endmodule

//--- source/tlb_lookup_exec.sv
// tag compare, hit select, fill victim choice and true-LRU age update
// fills are dropped while the array sweep runs
// a fill owns the age write of its cycle, a concurrent hit loses its refresh

module tlb_lookup_exec #(
  parameter int WAY_COUNT = tlb_cfg_pkg::DEFAULT_WAYS
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                fill_valid,
  input  logic [tlb_cfg_pkg::VPN_WIDTH-1:0]   fill_vpn,
  input  logic [tlb_cfg_pkg::ASID_WIDTH-1:0]  fill_asid,
  input  logic [tlb_cfg_pkg::PPN_WIDTH-1:0]   fill_ppn,
  input  tlb_types_pkg::page_attr_t           fill_attr,
  input  logic                                fill_invalidate,
  tlb_issue_if.sink                           issue,
  tlb_array_if.master                         array,
  tlb_result_if.source                        res
);

  localparam int WAY_W = $clog2(WAY_COUNT);
  localparam int AGE_W = $clog2(WAY_COUNT);
  localparam int LOOKUP_PORT = 0;
  localparam int FILL_PORT = 1;

  logic [WAY_COUNT-1:0]                look_match;
  logic [WAY_COUNT-1:0]                fill_match;
  logic                                look_hit;
  logic                                fill_hit;
  logic                                fill_act;
  logic [WAY_W-1:0]                    look_way;
  logic [WAY_W-1:0]                    fill_hit_way;
  logic [WAY_W-1:0]                    victim_way;
  logic [WAY_W-1:0]                    fill_way;
  logic [tlb_cfg_pkg::INDEX_WIDTH-1:0] fill_index;
  logic [tlb_cfg_pkg::TAG_WIDTH-1:0]   fill_tag;
  tlb_types_pkg::tlb_entry_t           hit_entry;
  tlb_types_pkg::tlb_entry_t           fill_entry;

  // global entries ignore the asid
  function automatic logic entry_match(input tlb_types_pkg::tlb_entry_t e,
                                       input logic [tlb_cfg_pkg::TAG_WIDTH-1:0] tag,
                                       input logic [tlb_cfg_pkg::ASID_WIDTH-1:0] asid);
    return e.valid && (e.tag == tag) && ((e.asid == asid) || e.attr.global_page);
  endfunction

  // refreshed way goes to age 0, every way younger than it ages by one
  function automatic logic [WAY_COUNT-1:0][AGE_W-1:0] refresh_ages(
      input logic [WAY_COUNT-1:0][AGE_W-1:0] ages, input logic [WAY_W-1:0] way);
    logic [WAY_COUNT-1:0][AGE_W-1:0] aged;
    aged = ages;
    for (int w = 0; w < WAY_COUNT; w++) begin
      if (ages[w] < ages[way]) aged[w] = ages[w] + 1'b1;
    end
    aged[way] = '0;
    return aged;
  endfunction

  assign fill_index = fill_vpn[tlb_cfg_pkg::INDEX_WIDTH-1:0];
  assign fill_tag = fill_vpn[tlb_cfg_pkg::VPN_WIDTH-1:tlb_cfg_pkg::INDEX_WIDTH];
  assign array.rd_index = {fill_index, issue.index};

  always_comb begin
    look_way = '0;
    fill_hit_way = '0;
    victim_way = '0;
    for (int w = 0; w < WAY_COUNT; w++) begin
      look_match[w] = entry_match(array.rd_entries[LOOKUP_PORT][w], issue.tag, issue.asid);
      fill_match[w] = entry_match(array.rd_entries[FILL_PORT][w], fill_tag, fill_asid);
      if (look_match[w]) look_way = WAY_W'(w);
      if (fill_match[w]) fill_hit_way = WAY_W'(w);
      // oldest way is the victim
      if (array.rd_ages[FILL_PORT][w] == AGE_W'(WAY_COUNT - 1)) victim_way = WAY_W'(w);
    end
  end

  assign look_hit = issue.valid && (|look_match);
  assign fill_hit = |fill_match;
  assign fill_way = fill_hit ? fill_hit_way : victim_way;
  assign fill_act = fill_valid && !array.init_busy;
  assign hit_entry = array.rd_entries[LOOKUP_PORT][look_way];

  always_comb begin
    if (fill_invalidate) begin
      fill_entry = array.rd_entries[FILL_PORT][fill_way];
      fill_entry.valid = 1'b0;
    end else begin
      fill_entry = '{valid: 1'b1, tag: fill_tag, asid: fill_asid, ppn: fill_ppn, attr: fill_attr};
    end
  end

  // invalidate of an absent page writes nothing
  assign array.wr_en = fill_act && (!fill_invalidate || fill_hit);
  assign array.wr_index = fill_index;
  assign array.wr_way = fill_way;
  assign array.wr_entry = fill_entry;

  always_comb begin
    if (fill_act && !fill_invalidate) begin
      array.age_wr_en = 1'b1;
      array.age_index = fill_index;
      array.new_ages = refresh_ages(array.rd_ages[FILL_PORT], fill_way);
    end else begin
      array.age_wr_en = look_hit;
      array.age_index = issue.index;
      array.new_ages = refresh_ages(array.rd_ages[LOOKUP_PORT], look_way);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) res.valid <= 1'b0;
    else res.valid <= issue.valid;
  end

  always_ff @(posedge clk) begin
    res.result.hit  <= look_hit;
    res.result.ppn  <= look_hit ? hit_entry.ppn : '0;
    res.result.attr <= look_hit ? hit_entry.attr : '0;
  end

endmodule

//--- source/tlb_req_decode.sv
// lookup request queue of REQ_DEPTH slots
// the requester must hold a credit for every lookup_valid, the queue never checks for overflow
// one pop per cycle, only while the array is idle and a result credit is granted

module tlb_req_decode #(
  parameter int REQ_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                lookup_valid,
  input  logic [tlb_cfg_pkg::VPN_WIDTH-1:0]   lookup_vpn,
  input  logic [tlb_cfg_pkg::ASID_WIDTH-1:0]  lookup_asid,
  input  logic                                issue_grant,
  input  logic                                init_busy,
  output logic                                lookup_credit,
  tlb_issue_if.source                         issue
);

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  logic [tlb_cfg_pkg::VPN_WIDTH-1:0]  vpn_q [REQ_DEPTH];
  logic [tlb_cfg_pkg::ASID_WIDTH-1:0] asid_q [REQ_DEPTH];
  logic [PTR_W-1:0]                   wr_ptr;
  logic [PTR_W-1:0]                   rd_ptr;
  logic [CNT_W-1:0]                   count;
  logic                               pop;

  // wraps at REQ_DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop = (count != '0) && !init_busy && issue_grant;

  // freeing a slot hands the credit back
  assign lookup_credit = pop;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (lookup_valid) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      if (lookup_valid && !pop) count <= count + 1'b1;
      else if (!lookup_valid && pop) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      vpn_q[wr_ptr]  <= lookup_vpn;
      asid_q[wr_ptr] <= lookup_asid;
    end
  end

  // issue stage, split the page number into set index and tag
  always_ff @(posedge clk) begin
    if (rst) issue.valid <= 1'b0;
    else issue.valid <= pop;
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      issue.index <= vpn_q[rd_ptr][tlb_cfg_pkg::INDEX_WIDTH-1:0];
      issue.tag   <= vpn_q[rd_ptr][tlb_cfg_pkg::VPN_WIDTH-1:tlb_cfg_pkg::INDEX_WIDTH];
      issue.asid  <= asid_q[rd_ptr];
    end
  end

endmodule

//--- source/tlb_ifs.sv
// interfaces between the decode, execute, array and result stages
// the array has two read ports, port 0 for lookups and port 1 for fills

interface tlb_issue_if;
  logic                                valid;
  logic [tlb_cfg_pkg::INDEX_WIDTH-1:0] index;
  logic [tlb_cfg_pkg::TAG_WIDTH-1:0]   tag;
  logic [tlb_cfg_pkg::ASID_WIDTH-1:0]  asid;

  modport source (output valid, index, tag, asid);
  modport sink (input valid, index, tag, asid);
endinterface

interface tlb_result_if;
  logic                          valid;
  tlb_types_pkg::lookup_result_t result;

  modport source (output valid, result);
  modport sink (input valid, result);
endinterface

interface tlb_array_if #(parameter int WAY_COUNT = tlb_cfg_pkg::DEFAULT_WAYS);
  localparam int WAY_W = $clog2(WAY_COUNT);
  localparam int AGE_W = $clog2(WAY_COUNT);

  logic [1:0][tlb_cfg_pkg::INDEX_WIDTH-1:0]      rd_index;
  tlb_types_pkg::tlb_entry_t [1:0][WAY_COUNT-1:0] rd_entries;
  logic [1:0][WAY_COUNT-1:0][AGE_W-1:0]          rd_ages;
  logic                                          wr_en;
  logic [tlb_cfg_pkg::INDEX_WIDTH-1:0]           wr_index;
  logic [WAY_W-1:0]                              wr_way;
  tlb_types_pkg::tlb_entry_t                     wr_entry;
  logic                                          age_wr_en;
  logic [tlb_cfg_pkg::INDEX_WIDTH-1:0]           age_index;
  logic [WAY_COUNT-1:0][AGE_W-1:0]               new_ages;
  logic                                          init_busy;

  modport master (output rd_index, wr_en, wr_index, wr_way, wr_entry, age_wr_en, age_index,
                  new_ages, input rd_entries, rd_ages, init_busy);
  modport slave (input rd_index, wr_en, wr_index, wr_way, wr_entry, age_wr_en, age_index,
                 new_ages, output rd_entries, rd_ages, init_busy);
endinterface

//--- source/tlb_types_pkg.sv
// entry, attribute and result layouts of the data TLB
// widths come from tlb_cfg_pkg, so both packages must be compiled in that order

package tlb_types_pkg;

  // permission and sharing flags of one page
  typedef struct packed {
    logic writable;
    logic user;
    logic global_page;
  } page_attr_t;

  // one stored translation, 46 bits with the default sizes
  typedef struct packed {
    logic                                 valid;
    logic [tlb_cfg_pkg::TAG_WIDTH-1:0]    tag;
    logic [tlb_cfg_pkg::ASID_WIDTH-1:0]   asid;
    logic [tlb_cfg_pkg::PPN_WIDTH-1:0]    ppn;
    page_attr_t                           attr;
  } tlb_entry_t;

  // what a lookup returns
  // ppn and attr are zero on a miss
  typedef struct packed {
    logic                                 hit;
    logic [tlb_cfg_pkg::PPN_WIDTH-1:0]    ppn;
    page_attr_t                           attr;
  } lookup_result_t;

endpackage

//--- source/tlb_cfg_pkg.sv
// sizes and widths of the data TLB
// SET_COUNT must equal 2**INDEX_WIDTH, and the tag is the page number above the index

package tlb_cfg_pkg;

  // virtual and physical page numbers
  localparam int VPN_WIDTH = 20;
  localparam int PPN_WIDTH = 18;

  // address-space id
  localparam int ASID_WIDTH = 8;

  // set geometry
  localparam int SET_COUNT = 16;
  localparam int INDEX_WIDTH = 4;
  localparam int TAG_WIDTH = VPN_WIDTH - INDEX_WIDTH;

  // ways per set unless the top level overrides it
  localparam int DEFAULT_WAYS = 4;

endpackage
